// File: src/alu_pkg.sv
package alu_pkg;

    // ******************************
    // Datapath widths
    // ******************************
    localparam int XLEN      = 64;
    localparam int NUM_PREGS = 32;
    localparam int NUM_FREGS = 8;
    localparam int PREG_W    = $clog2(NUM_PREGS);
    localparam int FREG_W    = $clog2(NUM_FREGS);
    localparam int IMM_W     = 12;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [FREG_W-1:0] freg_t;
    typedef logic [3:0]        nzcv_t;
    typedef logic [IMM_W-1:0]  imm_t;

    // Bit positions inside nzcv_t
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    typedef enum logic [3:0] {
        UOP_ADD  = 4'd0,
        UOP_SUB  = 4'd1,
        UOP_AND  = 4'd2,
        UOP_ORR  = 4'd3,
        UOP_EOR  = 4'd4,
        UOP_MVN  = 4'd5,
        UOP_UBFM = 4'd6,
        UOP_ASR  = 4'd7,
        UOP_MOVZ = 4'd8,
        UOP_MOVK = 4'd9
    } uop_e;

    // ******************************
    // APB register map
    // ******************************
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    typedef logic [APB_AW-1:0] apb_addr_t;
    typedef logic [APB_DW-1:0] apb_data_t;

    localparam apb_addr_t CSR_CTRL      = 8'h00;
    localparam apb_addr_t CSR_COUNT     = 8'h04;
    localparam apb_addr_t CSR_DBG_INDEX = 8'h08;
    localparam apb_addr_t CSR_DBG_LO    = 8'h0C;
    localparam apb_addr_t CSR_DBG_HI    = 8'h10;

endpackage

// File: src/exec_if.sv
`timescale 1ns/1ns

interface exec_if (
    input logic clk_in
);
    import alu_pkg::*;

    logic  valid;
    uop_e  op;
    imm_t  imm;
    logic  set_flags;
    preg_t dest;
    freg_t freg;
    word_t src0_val;
    word_t src1_val;
    word_t src2_val;
    nzcv_t old_flags;

    modport issue (
        output valid, op, imm, set_flags, dest, freg,
        output src0_val, src1_val, src2_val, old_flags
    );

    // Clock is only seen by the ALU for its checks
    modport alu (
        input clk_in,
        input valid, op, imm, set_flags, dest, freg,
        input src0_val, src1_val, src2_val, old_flags
    );

endinterface

// File: src/wb_if.sv
`timescale 1ns/1ns

interface wb_if;
    import alu_pkg::*;

    logic  reg_en;
    preg_t reg_index;
    word_t reg_data;

    logic  flag_en;
    freg_t flag_index;
    nzcv_t flag_data;

    modport alu (
        output reg_en, reg_index, reg_data,
        output flag_en, flag_index, flag_data
    );

    // Register files and the forwarding path
    modport sink (
        input reg_en, reg_index, reg_data,
        input flag_en, flag_index, flag_data
    );

endinterface

// File: src/issue_stage.sv
`timescale 1ns/1ns

module issue_stage (
    input  logic           clk_in,
    input  logic           reset,
    input  logic           uop_valid,
    input  alu_pkg::uop_e  uop_op,
    input  alu_pkg::preg_t uop_src0,
    input  alu_pkg::preg_t uop_src1,
    input  alu_pkg::preg_t uop_src2,
    input  alu_pkg::preg_t uop_dest,
    input  alu_pkg::freg_t uop_freg,
    input  alu_pkg::imm_t  uop_imm,
    input  logic           uop_set_flags,
    input  logic           enable,
    output logic           uop_ready,
    output alu_pkg::preg_t rd_index0,
    output alu_pkg::preg_t rd_index1,
    output alu_pkg::preg_t rd_index2,
    input  alu_pkg::word_t rd_data0,
    input  alu_pkg::word_t rd_data1,
    input  alu_pkg::word_t rd_data2,
    output alu_pkg::freg_t flag_rd_index,
    input  alu_pkg::nzcv_t flag_rd_data,
    wb_if.sink             wb,
    exec_if.issue          ex
);
    import alu_pkg::*;

    logic  fire;
    word_t src0_fwd;
    word_t src1_fwd;
    word_t src2_fwd;
    nzcv_t flags_fwd;

    assign uop_ready = enable;
    assign fire      = uop_valid && uop_ready;

    assign rd_index0     = uop_src0;
    assign rd_index1     = uop_src1;
    assign rd_index2     = uop_src2;
    assign flag_rd_index = uop_freg;

    // Bypass the result being written back this cycle
    assign src0_fwd = (wb.reg_en && wb.reg_index == uop_src0) ? wb.reg_data : rd_data0;
    assign src1_fwd = (wb.reg_en && wb.reg_index == uop_src1) ? wb.reg_data : rd_data1;
    assign src2_fwd = (wb.reg_en && wb.reg_index == uop_src2) ? wb.reg_data : rd_data2;
    assign flags_fwd = (wb.flag_en && wb.flag_index == uop_freg) ? wb.flag_data
                                                                 : flag_rd_data;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= fire;
        end
    end

    // Packet payload, only meaningful while valid
    always_ff @(posedge clk_in) begin
        if (fire) begin
            ex.op        <= uop_op;
            ex.imm       <= uop_imm;
            ex.set_flags <= uop_set_flags;
            ex.dest      <= uop_dest;
            ex.freg      <= uop_freg;
            ex.src0_val  <= src0_fwd;
            ex.src1_val  <= src1_fwd;
            ex.src2_val  <= src2_fwd;
            ex.old_flags <= flags_fwd;
        end
    end

    uop_op_known: assert property (@(posedge clk_in) disable iff (reset)
        fire |-> !$isunknown(uop_op));

endmodule

// File: src/int_alu.sv
`timescale 1ns/1ns

module int_alu (
    exec_if.alu ex,
    wb_if.alu   wb
);
    import alu_pkg::*;

    word_t         a;
    word_t         b;
    word_t         c;
    logic [5:0]    immr;
    logic [5:0]    imms;
    logic [5:0]    bf_len_m1;
    logic [1:0]    hw;
    logic [5:0]    hw_shift;
    logic [XLEN:0] add_full;
    word_t         sub_res;
    word_t         bf_mask;
    word_t         move_val;
    word_t         movk_mask;
    word_t         result;
    nzcv_t         flags;

    assign a = ex.src0_val;
    assign b = ex.src1_val;
    assign c = ex.src2_val;

    // Immediate fields for UBFM and the move-wide ops
    assign immr     = ex.imm[5:0];
    assign imms     = ex.imm[11:6];
    assign hw       = ex.imm[1:0];
    assign hw_shift = {hw, 4'b0000};

    assign add_full  = {1'b0, b} + {1'b0, c};
    assign sub_res   = b - c;
    assign bf_len_m1 = imms - immr;
    assign bf_mask   = {XLEN{1'b1}} >> (6'd63 - bf_len_m1);
    assign move_val  = word_t'(b[15:0]) << hw_shift;
    assign movk_mask = ~(word_t'(16'hFFFF) << hw_shift);

    // ******************************
    // Result select
    // ******************************
    always_comb begin
        case (ex.op)
            UOP_ADD:  result = add_full[XLEN-1:0];
            UOP_SUB:  result = sub_res;
            UOP_AND:  result = b & c;
            UOP_ORR:  result = b | c;
            UOP_EOR:  result = b ^ c;
            UOP_MVN:  result = ~b;
            UOP_UBFM: result = (a >> immr) & bf_mask;
            UOP_ASR:  result = word_t'($signed(a) >>> b[5:0]);
            UOP_MOVZ: result = move_val;
            UOP_MOVK: result = (a & movk_mask) | move_val;
            default:  result = '0;
        endcase
    end

    // ******************************
    // NZCV
    // ******************************
    always_comb begin
        flags         = ex.old_flags;
        flags[FLAG_N] = result[XLEN-1];
        flags[FLAG_Z] = (result == '0);
        case (ex.op)
            UOP_ADD: begin
                flags[FLAG_C] = add_full[XLEN];
                flags[FLAG_V] = (b[XLEN-1] == c[XLEN-1]) && (result[XLEN-1] != b[XLEN-1]);
            end
            UOP_SUB: begin
                // C set means no borrow
                flags[FLAG_C] = (b >= c);
                flags[FLAG_V] = (b[XLEN-1] != c[XLEN-1]) && (result[XLEN-1] != b[XLEN-1]);
            end
            default: ;
        endcase
    end

    assign wb.reg_en     = ex.valid;
    assign wb.reg_index  = ex.dest;
    assign wb.reg_data   = result;
    assign wb.flag_en    = ex.valid && ex.set_flags;
    assign wb.flag_index = ex.freg;
    assign wb.flag_data  = flags;

    // imms below immr is the unsupported bitfield form
    ubfm_field_order: assert property (@(posedge ex.clk_in)
        (ex.valid && ex.op == UOP_UBFM) |-> (imms >= immr));

endmodule

// File: src/phys_regfile.sv
`timescale 1ns/1ns

module phys_regfile (
    input  logic           clk_in,
    input  logic           reset,
    wb_if.sink             wb,
    input  logic           dbg_we,
    input  alu_pkg::preg_t dbg_index,
    input  alu_pkg::word_t dbg_wdata,
    input  alu_pkg::preg_t rd_index0,
    input  alu_pkg::preg_t rd_index1,
    input  alu_pkg::preg_t rd_index2,
    output alu_pkg::word_t rd_data0,
    output alu_pkg::word_t rd_data1,
    output alu_pkg::word_t rd_data2,
    input  alu_pkg::preg_t dbg_rd_index,
    output alu_pkg::word_t dbg_rd_data
);
    import alu_pkg::*;

    word_t regs [NUM_PREGS];

    // Write-back comes last so it wins on the same index
    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (dbg_we) begin
                regs[dbg_index] <= dbg_wdata;
            end
            if (wb.reg_en) begin
                regs[wb.reg_index] <= wb.reg_data;
            end
        end
    end

    assign rd_data0    = regs[rd_index0];
    assign rd_data1    = regs[rd_index1];
    assign rd_data2    = regs[rd_index2];
    assign dbg_rd_data = regs[dbg_rd_index];

    // Debug writes need issue disabled, so the pipe is drained
    dbg_wb_exclusive: assert property (@(posedge clk_in) disable iff (reset)
        !(dbg_we && wb.reg_en));

endmodule

// File: src/nzcv_file.sv
`timescale 1ns/1ns

module nzcv_file (
    input  logic           clk_in,
    input  logic           reset,
    wb_if.sink             wb,
    input  alu_pkg::freg_t rd_index,
    output alu_pkg::nzcv_t rd_data
);
    import alu_pkg::*;

    nzcv_t flag_regs [NUM_FREGS];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < NUM_FREGS; i++) begin
                flag_regs[i] <= '0;
            end
        end else if (wb.flag_en) begin
            flag_regs[wb.flag_index] <= wb.flag_data;
        end
    end

    assign rd_data = flag_regs[rd_index];

endmodule

// File: src/alu_csr.sv
`timescale 1ns/1ns

module alu_csr (
    input  logic               clk_in,
    input  logic               reset,
    input  alu_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  alu_pkg::apb_data_t pwdata,
    output alu_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic               exec_valid,
    output logic               enable,
    output logic               dbg_we,
    output alu_pkg::preg_t     dbg_index,
    output alu_pkg::word_t     dbg_wdata,
    input  alu_pkg::word_t     dbg_rd_data
);
    import alu_pkg::*;

    logic      access;
    logic      mapped;
    logic      err;
    logic      wr_ok;
    apb_data_t rd_mux;
    apb_data_t dbg_lo;
    apb_data_t count;

    // Second phase of a transfer
    assign access = psel && penable;
    assign pready = 1'b1;

    always_comb begin
        mapped = 1'b1;
        rd_mux = '0;
        case (paddr)
            CSR_CTRL:      rd_mux = {{(APB_DW-1){1'b0}}, enable};
            CSR_COUNT:     rd_mux = count;
            CSR_DBG_INDEX: rd_mux = apb_data_t'(dbg_index);
            CSR_DBG_LO:    rd_mux = dbg_rd_data[APB_DW-1:0];
            CSR_DBG_HI:    rd_mux = dbg_rd_data[XLEN-1:APB_DW];
            default:       mapped = 1'b0;
        endcase
    end

    assign err = !mapped
              || (pwrite && paddr == CSR_COUNT)
              || (pwrite && paddr == CSR_DBG_HI && enable);

    assign pslverr = access && err;
    assign prdata  = (access && !pwrite) ? rd_mux : '0;
    assign wr_ok   = access && pwrite && !err;

    // DBG_HI commits the staged low half in the same write
    assign dbg_we    = wr_ok && paddr == CSR_DBG_HI;
    assign dbg_wdata = {pwdata, dbg_lo};

    // ******************************
    // Registers
    // ******************************
    always_ff @(posedge clk_in) begin
        if (reset) begin
            enable    <= 1'b0;
            dbg_index <= '0;
            dbg_lo    <= '0;
            count     <= '0;
        end else begin
            if (exec_valid) begin
                count <= count + 1'b1;
            end
            if (wr_ok) begin
                case (paddr)
                    CSR_CTRL:      enable    <= pwdata[0];
                    CSR_DBG_INDEX: dbg_index <= pwdata[PREG_W-1:0];
                    CSR_DBG_LO:    dbg_lo    <= pwdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: src/alu_unit_top.sv
`timescale 1ns/1ns

module alu_unit_top (
    input  logic               clk_in,
    input  logic               reset,
    input  logic               uop_valid,
    output logic               uop_ready,
    input  alu_pkg::uop_e      uop_op,
    input  alu_pkg::preg_t     uop_src0,
    input  alu_pkg::preg_t     uop_src1,
    input  alu_pkg::preg_t     uop_src2,
    input  alu_pkg::preg_t     uop_dest,
    input  alu_pkg::freg_t     uop_freg,
    input  alu_pkg::imm_t      uop_imm,
    input  logic               uop_set_flags,
    output logic               wb_valid,
    output alu_pkg::preg_t     wb_index,
    output alu_pkg::word_t     wb_data,
    output logic               flag_valid,
    output alu_pkg::freg_t     flag_index,
    output alu_pkg::nzcv_t     flag_data,
    input  alu_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  alu_pkg::apb_data_t pwdata,
    output alu_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr
);
    import alu_pkg::*;

    preg_t rd_index0;
    preg_t rd_index1;
    preg_t rd_index2;
    word_t rd_data0;
    word_t rd_data1;
    word_t rd_data2;
    freg_t flag_rd_index;
    nzcv_t flag_rd_data;
    logic  enable;
    logic  dbg_we;
    preg_t dbg_index;
    word_t dbg_wdata;
    word_t dbg_rd_data;

    exec_if exec_bus (.clk_in(clk_in));
    wb_if   wb_bus ();

    issue_stage u_issue (
        .clk_in        (clk_in),
        .reset         (reset),
        .uop_valid     (uop_valid),
        .uop_op        (uop_op),
        .uop_src0      (uop_src0),
        .uop_src1      (uop_src1),
        .uop_src2      (uop_src2),
        .uop_dest      (uop_dest),
        .uop_freg      (uop_freg),
        .uop_imm       (uop_imm),
        .uop_set_flags (uop_set_flags),
        .enable        (enable),
        .uop_ready     (uop_ready),
        .rd_index0     (rd_index0),
        .rd_index1     (rd_index1),
        .rd_index2     (rd_index2),
        .rd_data0      (rd_data0),
        .rd_data1      (rd_data1),
        .rd_data2      (rd_data2),
        .flag_rd_index (flag_rd_index),
        .flag_rd_data  (flag_rd_data),
        .wb            (wb_bus.sink),
        .ex            (exec_bus.issue)
    );

    int_alu u_alu (
        .ex (exec_bus.alu),
        .wb (wb_bus.alu)
    );

    phys_regfile u_regfile (
        .clk_in       (clk_in),
        .reset        (reset),
        .wb           (wb_bus.sink),
        .dbg_we       (dbg_we),
        .dbg_index    (dbg_index),
        .dbg_wdata    (dbg_wdata),
        .rd_index0    (rd_index0),
        .rd_index1    (rd_index1),
        .rd_index2    (rd_index2),
        .rd_data0     (rd_data0),
        .rd_data1     (rd_data1),
        .rd_data2     (rd_data2),
        .dbg_rd_index (dbg_index),
        .dbg_rd_data  (dbg_rd_data)
    );

    nzcv_file u_nzcv (
        .clk_in   (clk_in),
        .reset    (reset),
        .wb       (wb_bus.sink),
        .rd_index (flag_rd_index),
        .rd_data  (flag_rd_data)
    );

    alu_csr u_csr (
        .clk_in      (clk_in),
        .reset       (reset),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .exec_valid  (exec_bus.valid),
        .enable      (enable),
        .dbg_we      (dbg_we),
        .dbg_index   (dbg_index),
        .dbg_wdata   (dbg_wdata),
        .dbg_rd_data (dbg_rd_data)
    );

    // Write-back is also the result stream
    assign wb_valid   = wb_bus.reg_en;
    assign wb_index   = wb_bus.reg_index;
    assign wb_data    = wb_bus.reg_data;
    assign flag_valid = wb_bus.flag_en;
    assign flag_index = wb_bus.flag_index;
    assign flag_data  = wb_bus.flag_data;

endmodule

// File: tests/tb_alu_unit.sv
`timescale 1ns/1ns

module tb_alu_unit;
    import alu_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic      clk_in;
    logic      reset;
    logic      uop_valid;
    logic      uop_ready;
    uop_e      uop_op;
    preg_t     uop_src0;
    preg_t     uop_src1;
    preg_t     uop_src2;
    preg_t     uop_dest;
    freg_t     uop_freg;
    imm_t      uop_imm;
    logic      uop_set_flags;
    logic      wb_valid;
    preg_t     wb_index;
    word_t     wb_data;
    logic      flag_valid;
    freg_t     flag_index;
    nzcv_t     flag_data;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    // Reference copies of the register and flag files
    word_t model_regs [NUM_PREGS];
    nzcv_t model_flags [NUM_FREGS];

    // Result expected on the write-back outputs in the current cycle
    logic  pend_valid;
    preg_t pend_dest;
    word_t pend_data;
    logic  pend_set;
    freg_t pend_freg;
    nzcv_t pend_flags;

    int accepted;
    int cycle_count;
    int ubfm_r [5] = '{0, 4, 60, 17, 8};
    int ubfm_s [5] = '{63, 11, 63, 17, 39};

    alu_unit_top u_dut (.*);

    always #50 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("sim failed");
            $fatal(1, "Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("sim failed");
            $fatal(1, "Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // ******************************
    // APB access
    // ******************************
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(posedge clk_in);
        #1;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk_in);
        #1;
        penable = 1'b1;
        @(negedge clk_in);
        check("pready", pready, 1);
        err = pslverr;
        @(posedge clk_in);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk_in);
        #1;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk_in);
        #1;
        penable = 1'b1;
        @(negedge clk_in);
        check("pready", pready, 1);
        data = prdata;
        err  = pslverr;
        @(posedge clk_in);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic preload_reg(input preg_t idx, input word_t value);
        logic err;
        apb_write(CSR_DBG_INDEX, apb_data_t'(idx), err);
        check("pslverr", err, 0);
        apb_write(CSR_DBG_LO, value[31:0], err);
        check("pslverr", err, 0);
        apb_write(CSR_DBG_HI, value[63:32], err);
        check("pslverr", err, 0);
        model_regs[idx] = value;
    endtask

    task automatic readback_reg(input preg_t idx);
        logic      err;
        apb_data_t lo;
        apb_data_t hi;
        apb_write(CSR_DBG_INDEX, apb_data_t'(idx), err);
        check("pslverr", err, 0);
        apb_read(CSR_DBG_LO, lo, err);
        check("pslverr", err, 0);
        apb_read(CSR_DBG_HI, hi, err);
        check("pslverr", err, 0);
        check($sformatf("reg[%0d]", idx), {hi, lo}, model_regs[idx]);
    endtask

    // ******************************
    // Reference ALU
    // ******************************
    function automatic void model_exec(input uop_e op, input word_t a, input word_t b,
                                       input word_t c, input imm_t imm, input nzcv_t old,
                                       output word_t res, output nzcv_t f);
        int width;
        int base;
        int sh;
        width = int'(imm[11:6]) - int'(imm[5:0]) + 1;
        base  = int'(imm[1:0]) * 16;
        sh    = int'(b[5:0]);
        res   = '0;
        case (op)
            UOP_ADD: res = b + c;
            UOP_SUB: res = b - c;
            UOP_AND: res = b & c;
            UOP_ORR: res = b | c;
            UOP_EOR: res = b ^ c;
            UOP_MVN: res = ~b;
            UOP_UBFM: begin
                for (int i = 0; i < width; i++) begin
                    res[i] = a[int'(imm[5:0]) + i];
                end
            end
            UOP_ASR: begin
                res = a;
                for (int i = 0; i < sh; i++) begin
                    res = {res[63], res[63:1]};
                end
            end
            UOP_MOVZ: res[base +: 16] = b[15:0];
            UOP_MOVK: begin
                res = a;
                res[base +: 16] = b[15:0];
            end
            default: res = '0;
        endcase
        f         = old;
        f[FLAG_N] = res[63];
        f[FLAG_Z] = (res == 64'd0);
        if (op == UOP_ADD) begin
            // A wrapped sum is smaller than either addend
            f[FLAG_C] = (res < b);
            f[FLAG_V] = (!b[63] && !c[63] && res[63]) || (b[63] && c[63] && !res[63]);
        end else if (op == UOP_SUB) begin
            f[FLAG_C] = !(b < c);
            f[FLAG_V] = (b[63] && !c[63] && !res[63]) || (!b[63] && c[63] && res[63]);
        end
    endfunction

    // ******************************
    // Micro-op issue
    // ******************************
    task automatic compare_writeback();
        if (pend_valid) begin
            check("wb_valid", wb_valid, 1);
            check("wb_index", wb_index, pend_dest);
            check("wb_data", wb_data, pend_data);
            check("flag_valid", flag_valid, pend_set);
            if (pend_set) begin
                check("flag_index", flag_index, pend_freg);
                check("flag_data", flag_data, pend_flags);
            end
            pend_valid = 1'b0;
        end
    endtask

    task automatic issue_uop(input uop_e op, input preg_t s0, input preg_t s1,
                             input preg_t s2, input preg_t dest, input freg_t freg,
                             input imm_t imm, input logic set_flags);
        word_t res;
        nzcv_t f;
        uop_valid     = 1'b1;
        uop_op        = op;
        uop_src0      = s0;
        uop_src1      = s1;
        uop_src2      = s2;
        uop_dest      = dest;
        uop_freg      = freg;
        uop_imm       = imm;
        uop_set_flags = set_flags;
        model_exec(op, model_regs[s0], model_regs[s1], model_regs[s2], imm,
                   model_flags[freg], res, f);
        @(negedge clk_in);
        // The previous micro-op is on write-back while this one waits
        compare_writeback();
        while (uop_ready !== 1'b1) begin
            @(negedge clk_in);
        end
        @(posedge clk_in);
        #1;
        uop_valid        = 1'b0;
        model_regs[dest] = res;
        if (set_flags) begin
            model_flags[freg] = f;
        end
        pend_valid = 1'b1;
        pend_dest  = dest;
        pend_data  = res;
        pend_set   = set_flags;
        pend_freg  = freg;
        pend_flags = f;
        accepted   = accepted + 1;
    endtask

    task automatic finish_issue();
        @(negedge clk_in);
        compare_writeback();
        @(posedge clk_in);
        #1;
    endtask

    initial begin
        logic      err;
        apb_data_t rdata;
        word_t     value;

        void'($urandom(65));
        clk_in        = 1'b0;
        reset         = 1'b1;
        uop_valid     = 1'b0;
        uop_op        = UOP_ADD;
        uop_src0      = '0;
        uop_src1      = '0;
        uop_src2      = '0;
        uop_dest      = '0;
        uop_freg      = '0;
        uop_imm       = '0;
        uop_set_flags = 1'b0;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        pend_valid    = 1'b0;
        accepted      = 0;
        cycle_count   = 0;
        for (int i = 0; i < NUM_PREGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < NUM_FREGS; i++) begin
            model_flags[i] = '0;
        end
        repeat (5) @(posedge clk_in);
        #1;
        reset = 1'b0;

        // Reset defaults
        @(negedge clk_in);
        check("uop_ready", uop_ready, 0);
        check("wb_valid", wb_valid, 0);
        check("flag_valid", flag_valid, 0);
        check("pslverr", pslverr, 0);
        apb_read(CSR_CTRL, rdata, err);
        check("CTRL", rdata, 0);
        apb_read(CSR_COUNT, rdata, err);
        check("COUNT", rdata, 0);
        apb_read(CSR_DBG_LO, rdata, err);
        check("DBG_LO", rdata, 0);

        // Debug preload with corner operands
        preload_reg(1, {$urandom(), $urandom()});
        preload_reg(2, {$urandom(), $urandom()});
        preload_reg(3, 64'hFFFF_FFFF_FFFF_FFFF);
        preload_reg(4, 64'd1);
        preload_reg(5, 64'h7FFF_FFFF_FFFF_FFFF);
        preload_reg(6, 64'h8000_0000_0000_0000);
        preload_reg(7, {$urandom(), $urandom()});
        value = {$urandom(), $urandom()};
        preload_reg(8, {1'b1, value[62:0]});
        for (int i = 1; i <= 8; i++) begin
            readback_reg(preg_t'(i));
        end
        apb_read(8'h14, rdata, err);
        check("pslverr on unmapped read", err, 1);
        apb_write(CSR_COUNT, 32'd5, err);
        check("pslverr on COUNT write", err, 1);
        apb_write(CSR_CTRL, 32'd1, err);
        check("pslverr", err, 0);
        apb_write(CSR_DBG_INDEX, 32'd3, err);
        apb_write(CSR_DBG_LO, $urandom(), err);
        apb_write(CSR_DBG_HI, $urandom(), err);
        check("pslverr on DBG_HI write while enabled", err, 1);
        readback_reg(3);

        // Arithmetic and flags
        issue_uop(UOP_ADD, 0, 1, 2, 16, 1, 0, 1);
        issue_uop(UOP_ADD, 0, 3, 4, 17, 2, 0, 1);
        issue_uop(UOP_ADD, 0, 5, 4, 18, 3, 0, 1);
        issue_uop(UOP_SUB, 0, 1, 1, 19, 4, 0, 1);
        issue_uop(UOP_SUB, 0, 4, 3, 20, 5, 0, 1);
        issue_uop(UOP_SUB, 0, 6, 4, 21, 6, 0, 1);
        issue_uop(UOP_SUB, 0, 2, 7, 22, 7, 0, 1);
        issue_uop(UOP_AND, 0, 3, 8, 23, 2, 0, 1);
        issue_uop(UOP_AND, 0, 5, 6, 24, 3, 0, 1);
        finish_issue();

        // Logic, bitfield and move operations
        issue_uop(UOP_AND, 0, 1, 7, 25, 0, 0, 0);
        issue_uop(UOP_ORR, 0, 1, 7, 26, 0, 0, 1);
        issue_uop(UOP_EOR, 0, 2, 8, 27, 1, 0, 1);
        issue_uop(UOP_MVN, 0, 8, 0, 28, 0, 0, 1);
        for (int i = 0; i < 5; i++) begin
            issue_uop(UOP_UBFM, 8, 0, 0, 29, 1, {6'(ubfm_s[i]), 6'(ubfm_r[i])}, 1);
        end
        issue_uop(UOP_ASR, 8, 1, 0, 30, 0, 0, 1);
        issue_uop(UOP_ASR, 8, 4, 0, 30, 0, 0, 1);
        issue_uop(UOP_ASR, 6, 3, 0, 30, 0, 0, 1);
        issue_uop(UOP_ASR, 8, 9, 0, 30, 0, 0, 1);
        for (int hw = 0; hw < 4; hw++) begin
            issue_uop(UOP_MOVZ, 0, 2, 0, 31, 0, imm_t'(hw), 0);
        end
        for (int hw = 0; hw < 4; hw++) begin
            issue_uop(UOP_MOVK, 31, preg_t'(hw + 1), 0, 31, 0, imm_t'(hw), 0);
        end
        finish_issue();

        // Dependent chain on consecutive cycles
        issue_uop(UOP_ADD, 0, 3, 4, 20, 4, 0, 1);
        issue_uop(UOP_SUB, 0, 20, 7, 21, 4, 0, 1);
        issue_uop(UOP_EOR, 0, 21, 20, 22, 4, 0, 1);
        issue_uop(UOP_MOVK, 22, 1, 0, 22, 4, 2, 0);
        issue_uop(UOP_ASR, 22, 4, 0, 23, 4, 0, 1);
        issue_uop(UOP_ORR, 0, 23, 22, 20, 4, 0, 1);
        issue_uop(UOP_UBFM, 20, 0, 0, 24, 5, {6'd40, 6'd3}, 1);
        issue_uop(UOP_MVN, 0, 24, 0, 25, 5, 0, 1);
        finish_issue();
        apb_write(CSR_CTRL, 32'd0, err);
        check("pslverr", err, 0);
        for (int i = 20; i <= 25; i++) begin
            readback_reg(preg_t'(i));
        end

        // Disabled issue and final count
        uop_valid = 1'b1;
        uop_op    = UOP_ADD;
        uop_dest  = 5'd9;
        repeat (4) begin
            @(negedge clk_in);
            check("uop_ready", uop_ready, 0);
            check("wb_valid", wb_valid, 0);
            @(posedge clk_in);
            #1;
        end
        uop_valid = 1'b0;
        apb_read(CSR_COUNT, rdata, err);
        check("COUNT", rdata, accepted);

        $display("sim passed");
        $finish;
    end

endmodule

// File: alu_unit.f
src/alu_pkg.sv
src/exec_if.sv
src/wb_if.sv
src/issue_stage.sv
src/int_alu.sv
src/phys_regfile.sv
src/nzcv_file.sv
src/alu_csr.sv
src/alu_unit_top.sv
tests/tb_alu_unit.sv

// File: Bender.yml
package:
  name: alu_unit

sources:
  - src/alu_pkg.sv
  - src/exec_if.sv
  - src/wb_if.sv
  - src/issue_stage.sv
  - src/int_alu.sv
  - src/phys_regfile.sv
  - src/nzcv_file.sv
  - src/alu_csr.sv
  - src/alu_unit_top.sv
  - target: simulation
    files:
      - tests/tb_alu_unit.sv
